// ==== verilog.f ====
common/cdb_pkg.sv
hdl/result_fifo.sv
ieu/ieu_decode.sv
ieu/ieu_alu.sv
ieu/ieu.sv
hdl/cdb_arbiter.sv
hdl/exec_cluster.sv
bench/tb_exec_cluster.sv

// ==== Bender.yml ====
package:
  name: exec_cluster

sources:
  # Shared package first
  - common/cdb_pkg.sv
  # Result queue and execution unit
  - hdl/result_fifo.sv
  - ieu/ieu_decode.sv
  - ieu/ieu_alu.sv
  - ieu/ieu.sv
  # Arbiter and top level
  - hdl/cdb_arbiter.sv
  - hdl/exec_cluster.sv
  # Testbench
  - target: test
    files:
      - bench/tb_exec_cluster.sv

// ==== bench/tb_exec_cluster.sv ====
// Table-driven testbench for the execution back end. Issues RV32I
// instructions on both units, checks every CDB broadcast against a
// scoreboard keyed by tag and covers contention, back-pressure and flush
module tb_exec_cluster;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF        = 20;
    localparam int NUM_ENTRIES     = 24;
    localparam int TAG_COUNT       = 2 ** cdb_pkg::TAG_WIDTH;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 20;

    localparam int ST_IDLE    = 0;
    localparam int ST_PENDING = 1;
    localparam int ST_DONE    = 2;
    localparam int ST_FLUSHED = 3;

    typedef struct packed {
        int          unit;
        logic [31:0] insn;
        logic [31:0] iaddr;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [31:0] data;
        logic [31:0] addr;
        logic        redirect;
    } vec_t;

    // unit, insn, iaddr, src_a, src_b, expected data, expected addr, expected redirect
    localparam vec_t TABLE [NUM_ENTRIES] = '{
        '{0, 32'h002081B3, 32'h1000, 32'h5, 32'h7, 32'hC, 32'h1004, 1'b0},
        '{1, 32'h402081B3, 32'h1004, 32'h3, 32'h5, 32'hFFFFFFFE, 32'h1008, 1'b0},
        '{0, 32'h002091B3, 32'h1008, 32'h1, 32'h24, 32'h10, 32'h100C, 1'b0},
        '{1, 32'h0020A1B3, 32'h100C, 32'hFFFFFFFF, 32'h1, 32'h1, 32'h1010, 1'b0},
        '{0, 32'h0020B1B3, 32'h1010, 32'hFFFFFFFF, 32'h1, 32'h0, 32'h1014, 1'b0},
        '{1, 32'h0020C1B3, 32'h1014, 32'hF0F0F0F0, 32'h0FF00FF0, 32'hFF00FF00, 32'h1018, 1'b0},
        '{0, 32'h0020D1B3, 32'h1018, 32'h80000000, 32'h4, 32'h08000000, 32'h101C, 1'b0},
        '{1, 32'h4020D1B3, 32'h101C, 32'h80000000, 32'h4, 32'hF8000000, 32'h1020, 1'b0},
        '{0, 32'h0020E1B3, 32'h1020, 32'h12340000, 32'h5678, 32'h12345678, 32'h1024, 1'b0},
        '{1, 32'h0020F1B3, 32'h1024, 32'hFFFF0000, 32'h0F0F0F0F, 32'h0F0F0000, 32'h1028, 1'b0},
        '{0, 32'hFFB08193, 32'h1028, 32'h10, 32'hDEADBEEF, 32'hB, 32'h102C, 1'b0},
        '{1, 32'h0FF0C193, 32'h102C, 32'hFFFF, 32'h0, 32'hFF00, 32'h1030, 1'b0},
        '{0, 32'hFFF0A193, 32'h1030, 32'hFFFFFFFE, 32'h0, 32'h1, 32'h1034, 1'b0},
        '{1, 32'h4040D193, 32'h1034, 32'h80000010, 32'h0, 32'hF8000001, 32'h1038, 1'b0},
        '{0, 32'hABCDE1B7, 32'h1038, 32'h0, 32'h0, 32'hABCDE000, 32'h103C, 1'b0},
        '{1, 32'h12345197, 32'h103C, 32'h0, 32'h0, 32'h1234603C, 32'h1040, 1'b0},
        '{0, 32'h100000EF, 32'h1040, 32'h0, 32'h0, 32'h1044, 32'h1140, 1'b1},
        '{1, 32'h00C280E7, 32'h1044, 32'h2001, 32'h0, 32'h1048, 32'h200C, 1'b1},
        '{0, 32'h00208463, 32'h1048, 32'h7, 32'h7, 32'h0, 32'h1050, 1'b1},
        '{1, 32'h00209463, 32'h104C, 32'h7, 32'h7, 32'h0, 32'h1050, 1'b0},
        '{0, 32'hFE20CCE3, 32'h1050, 32'hFFFFFFF0, 32'h1, 32'h0, 32'h1048, 1'b1},
        '{1, 32'h0020D863, 32'h1054, 32'h1, 32'hFFFFFFFF, 32'h0, 32'h1064, 1'b1},
        '{0, 32'h0020E463, 32'h1058, 32'hFFFFFFFF, 32'h1, 32'h0, 32'h105C, 1'b0},
        '{1, 32'hFF1FF0EF, 32'h105C, 32'h0, 32'h0, 32'h1060, 32'h104C, 1'b1}
    };

    logic                       clk = 1'b0;
    logic                       n_rst;
    logic                       flush;
    cdb_pkg::rs_issue_t         issue [cdb_pkg::NUM_FU];
    logic [cdb_pkg::NUM_FU-1:0] stall;
    cdb_pkg::cdb_t              cdb;

    // Scoreboard indexed by tag, plus per-unit issue order
    cdb_pkg::cdb_t expected [TAG_COUNT];
    int            tag_state [TAG_COUNT];
    int            unit_of [TAG_COUNT];
    int            order_q [cdb_pkg::NUM_FU][TAG_COUNT];
    int            ord_head [cdb_pkg::NUM_FU];
    int            ord_tail [cdb_pkg::NUM_FU];
    int            n_pending;
    int            n_issued;
    int            n_flushed;
    int            stall_cycles;
    logic [31:0]   lcg_state [cdb_pkg::NUM_FU];

    exec_cluster i_dut (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (flush),
        .i_issue (issue),
        .o_stall (stall),
        .o_cdb   (cdb)
    );

    initial begin
        forever #CLK_HALF clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val) begin
            stop_with_failure($sformatf("MISMATCH %s: expected 0x%08h, got 0x%08h",
                                        name, exp_val, act_val));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Idle cycles of 0 to 3 between issues, one generator per unit
    function automatic int idle_gap(input int u);
        lcg_state[u] = lcg_next(lcg_state[u]);
        return int'(lcg_state[u][17:16]);
    endfunction

    function automatic int tag_of(input int pass, input int idx);
        return (pass * NUM_ENTRIES + idx) % TAG_COUNT;
    endfunction

    // Starts and ends on a falling edge; holds the instruction while stalled
    task automatic issue_entry(input int u, input int idx, input int tag);
        vec_t v;
        v = TABLE[idx];
        issue[u].valid = 1'b1;
        issue[u].insn  = v.insn;
        issue[u].iaddr = v.iaddr;
        issue[u].src_a = v.src_a;
        issue[u].src_b = v.src_b;
        issue[u].tag   = cdb_pkg::TAG_WIDTH'(tag);
        while (stall[u]) begin
            stall_cycles++;
            @(negedge clk);
        end
        expected[tag].valid    = 1'b1;
        expected[tag].data     = v.data;
        expected[tag].addr     = v.addr;
        expected[tag].tag      = cdb_pkg::TAG_WIDTH'(tag);
        expected[tag].redirect = v.redirect;
        tag_state[tag] = ST_PENDING;
        unit_of[tag]   = u;
        order_q[u][ord_tail[u] % TAG_COUNT] = tag;
        ord_tail[u]++;
        n_pending++;
        n_issued++;
        @(negedge clk);
        issue[u].valid = 1'b0;
    endtask

    task automatic run_unit(input int u, input int pass, input int first, input int last,
                            input bit gaps);
        for (int idx = first; idx <= last; idx++) begin
            if (TABLE[idx].unit == u) begin
                issue_entry(u, idx, tag_of(pass, idx));
                if (gaps) begin
                    repeat (idle_gap(u)) @(negedge clk);
                end
            end
        end
    endtask

    task automatic run_pass(input int pass, input int first, input int last, input bit gaps);
        fork
            run_unit(0, pass, first, last, gaps);
            run_unit(1, pass, first, last, gaps);
        join
    endtask

    // Polled on the rising edge, where the monitor is quiet
    task automatic wait_drained();
        while (n_pending != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic flush_in_flight();
        flush = 1'b1;
        @(posedge clk);
        for (int t = 0; t < TAG_COUNT; t++) begin
            if (tag_state[t] == ST_PENDING) begin
                tag_state[t] = ST_FLUSHED;
                n_flushed++;
            end
        end
        for (int u = 0; u < cdb_pkg::NUM_FU; u++) begin
            ord_head[u] = ord_tail[u];
        end
        n_pending = 0;
        @(negedge clk);
        flush = 1'b0;
    endtask

    // Lone issue on unit 0 must be on the CDB two cycles after acceptance
    task automatic check_latency();
        issue_entry(0, 0, 0);
        check_value("o_cdb.valid", 32'h0, cdb.valid);
        @(negedge clk);
        check_value("o_cdb.valid", 32'h1, cdb.valid);
        check_value("o_cdb.tag", 32'h0, cdb.tag);
    endtask

    task automatic check_broadcast();
        int t;
        int u;
        t = cdb.tag;
        if (tag_state[t] != ST_PENDING) begin
            stop_with_failure($sformatf("CDB broadcast of tag %0d, which awaits no result", t));
        end
        u = unit_of[t];
        if (order_q[u][ord_head[u] % TAG_COUNT] != t) begin
            stop_with_failure($sformatf("Tag %0d of unit %0d reached the CDB out of order",
                                        t, u));
        end
        check_value("o_cdb.data", expected[t].data, cdb.data);
        check_value("o_cdb.addr", expected[t].addr, cdb.addr);
        check_value("o_cdb.redirect", expected[t].redirect, cdb.redirect);
        ord_head[u]++;
        tag_state[t] = ST_DONE;
        n_pending--;
    endtask

    always @(negedge clk) begin
        if (n_rst && cdb.valid === 1'b1) begin
            check_broadcast();
        end else if (n_rst && cdb.valid !== 1'b0) begin
            stop_with_failure("o_cdb.valid is unknown after reset");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure($sformatf("Timeout after %0d cycles with %0d results still missing",
                                    WATCHDOG_CYCLES, n_pending));
    end

    initial begin
        n_rst = 1'b0;
        flush = 1'b0;
        n_pending = 0;
        n_issued = 0;
        n_flushed = 0;
        stall_cycles = 0;
        for (int u = 0; u < cdb_pkg::NUM_FU; u++) begin
            issue[u]     = '0;
            ord_head[u]  = 0;
            ord_tail[u]  = 0;
            lcg_state[u] = 32'hd7cb + u;
        end
        for (int t = 0; t < TAG_COUNT; t++) begin
            tag_state[t] = ST_IDLE;
            unit_of[t]   = 0;
        end
        repeat (10) @(negedge clk);
        n_rst = 1'b1;
        check_value("o_cdb.valid", 32'h0, cdb.valid);
        check_value("o_stall", 32'h0, stall);
        // Quiet bus before the first issue
        repeat (4) @(negedge clk);
        check_latency();
        wait_drained();
        run_pass(0, 0, NUM_ENTRIES - 1, 1'b1);
        wait_drained();
        // Both units back to back fill the queues and may raise stall
        run_pass(1, 0, NUM_ENTRIES - 1, 1'b0);
        wait_drained();
        run_pass(2, 0, NUM_ENTRIES / 2 - 1, 1'b0);
        flush_in_flight();
        run_pass(2, NUM_ENTRIES / 2, NUM_ENTRIES - 1, 1'b1);
        wait_drained();
        repeat (4) @(negedge clk);
        $display("Issued %0d, flushed %0d, stall cycles %0d", n_issued, n_flushed, stall_cycles);
        if (n_flushed == 0) begin
            stop_with_failure("Flush found no results in flight");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== hdl/exec_cluster.sv ====
// Execution back end: NUM_FU integer units sharing one CDB through
// a round-robin arbiter. Each unit has its own issue port and stall
module exec_cluster (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic                        i_flush,
    input  cdb_pkg::rs_issue_t          i_issue [cdb_pkg::NUM_FU],
    output logic [cdb_pkg::NUM_FU-1:0]  o_stall,
    output cdb_pkg::cdb_t               o_cdb
);

    logic [cdb_pkg::NUM_FU-1:0] req;
    logic [cdb_pkg::NUM_FU-1:0] gnt;
    cdb_pkg::cdb_t              head [cdb_pkg::NUM_FU];

    for (genvar fu = 0; fu < cdb_pkg::NUM_FU; fu++) begin : g_fu
        ieu i_ieu (
            .clk     (clk),
            .n_rst   (n_rst),
            .i_flush (i_flush),
            .i_issue (i_issue[fu]),
            .o_stall (o_stall[fu]),
            .i_gnt   (gnt[fu]),
            .o_req   (req[fu]),
            .o_head  (head[fu])
        );
    end

    cdb_arbiter i_arbiter (
        .clk    (clk),
        .n_rst  (n_rst),
        .i_req  (req),
        .i_head (head),
        .o_gnt  (gnt),
        .o_cdb  (o_cdb)
    );

endmodule

// ==== hdl/cdb_arbiter.sv ====
// Round-robin arbiter for the common data bus. Grants one requesting
// unit per cycle, searching from the one after the last winner
module cdb_arbiter (
    input  logic                        clk,
    input  logic                        n_rst,
    input  logic [cdb_pkg::NUM_FU-1:0]  i_req,
    input  cdb_pkg::cdb_t               i_head [cdb_pkg::NUM_FU],
    output logic [cdb_pkg::NUM_FU-1:0]  o_gnt,
    output cdb_pkg::cdb_t               o_cdb
);

    logic [cdb_pkg::FU_IDX_WIDTH-1:0] last_q;
    logic [cdb_pkg::FU_IDX_WIDTH-1:0] win_idx;
    logic                             win_any;

    always_comb begin
        int unsigned idx;
        win_idx = last_q;
        win_any = 1'b0;
        o_gnt   = '0;
        o_cdb   = '0;
        for (int unsigned i = 1; i <= cdb_pkg::NUM_FU; i++) begin
            idx = (int'(last_q) + i) % cdb_pkg::NUM_FU;
            if (!win_any && i_req[idx]) begin
                win_any = 1'b1;
                win_idx = cdb_pkg::FU_IDX_WIDTH'(idx);
            end
        end
        if (win_any) begin
            o_gnt[win_idx] = 1'b1;
            o_cdb          = i_head[win_idx];
            o_cdb.valid    = 1'b1;
        end
    end

    // Start so that unit 0 has priority after reset
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            last_q <= cdb_pkg::FU_IDX_WIDTH'(cdb_pkg::NUM_FU - 1);
        end else if (win_any) begin
            last_q <= win_idx;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!n_rst) $onehot0(o_gnt));

    a_gnt_has_req: assert property (
        @(posedge clk) disable iff (!n_rst)
        (o_gnt & ~i_req) == '0
    );

endmodule

// ==== ieu/ieu.sv ====
// Integer execution unit. Decodes issued instructions, registers them
// into EX, queues the results and requests the CDB while the queue holds any
module ieu (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               i_flush,
    input  cdb_pkg::rs_issue_t i_issue,
    output logic               o_stall,
    input  logic               i_gnt,
    output logic               o_req,
    output cdb_pkg::cdb_t      o_head
);

    cdb_pkg::decoded_t                   dec;
    cdb_pkg::decoded_t                   id_ex_q;
    cdb_pkg::decoded_t                   ex_in;
    cdb_pkg::cdb_t                       ex_result;
    logic                                id_ex_valid;
    logic                                accept;
    logic                                fifo_empty;
    logic                                fifo_full;
    logic [cdb_pkg::FIFO_CNT_WIDTH-1:0]  fifo_count;
    logic [cdb_pkg::FIFO_CNT_WIDTH:0]    occupancy;

    assign accept = i_issue.valid & ~o_stall;

    // Queued results plus the one in EX must leave two free slots
    assign occupancy = {1'b0, fifo_count} + {{cdb_pkg::FIFO_CNT_WIDTH{1'b0}}, id_ex_valid};
    assign o_stall   = occupancy > (cdb_pkg::FIFO_CNT_WIDTH + 1)'(cdb_pkg::RESULT_FIFO_DEPTH - 2);

    ieu_decode i_decode (
        .i_issue (i_issue),
        .o_dec   (dec)
    );

    // An issue on a flush cycle is dropped along with the rest
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            id_ex_valid <= 1'b0;
        end else if (i_flush) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_ex_q <= dec;
        end
    end

    always_comb begin
        ex_in       = id_ex_q;
        ex_in.valid = id_ex_valid;
    end

    ieu_alu i_alu (
        .i_dec    (ex_in),
        .o_result (ex_result)
    );

    result_fifo #(
        .DEPTH (cdb_pkg::RESULT_FIFO_DEPTH)
    ) i_fifo (
        .clk     (clk),
        .n_rst   (n_rst),
        .i_flush (i_flush),
        .i_wr    (ex_result.valid),
        .i_data  (ex_result),
        .i_rd    (i_gnt),
        .o_data  (o_head),
        .o_empty (fifo_empty),
        .o_full  (fifo_full),
        .o_count (fifo_count)
    );

    assign o_req = ~fifo_empty;

    // A result leaving EX never meets a full queue
    a_room_for_result: assert property (
        @(posedge clk) disable iff (!n_rst || i_flush)
        ex_result.valid |-> !fifo_full
    );

endmodule

// ==== ieu/ieu_alu.sv ====
// EX stage of an integer unit. Computes the result, resolves branches
// and jumps and forms the CDB broadcast for the result queue
module ieu_alu (
    input  cdb_pkg::decoded_t i_dec,
    output cdb_pkg::cdb_t     o_result
);

    logic [cdb_pkg::DATA_WIDTH-1:0] alu_res;
    logic [cdb_pkg::ADDR_WIDTH-1:0] link_addr;
    logic [cdb_pkg::ADDR_WIDTH-1:0] br_target;
    logic [cdb_pkg::ADDR_WIDTH-1:0] jalr_sum;
    logic [4:0]                     shamt;
    logic                           eq;
    logic                           lt_s;
    logic                           lt_u;
    logic                           taken;
    logic                           redirect;

    assign shamt = i_dec.op_b[4:0];
    assign eq    = (i_dec.op_a == i_dec.op_b);
    assign lt_s  = ($signed(i_dec.op_a) < $signed(i_dec.op_b));
    assign lt_u  = (i_dec.op_a < i_dec.op_b);

    always_comb begin
        alu_res = '0;
        taken   = 1'b0;
        case (i_dec.alu_func)
            cdb_pkg::ALU_ADD:  alu_res = i_dec.op_a + i_dec.op_b;
            cdb_pkg::ALU_SUB:  alu_res = i_dec.op_a - i_dec.op_b;
            cdb_pkg::ALU_SLL:  alu_res = i_dec.op_a << shamt;
            cdb_pkg::ALU_SLT:  alu_res = {{(cdb_pkg::DATA_WIDTH-1){1'b0}}, lt_s};
            cdb_pkg::ALU_SLTU: alu_res = {{(cdb_pkg::DATA_WIDTH-1){1'b0}}, lt_u};
            cdb_pkg::ALU_XOR:  alu_res = i_dec.op_a ^ i_dec.op_b;
            cdb_pkg::ALU_SRL:  alu_res = i_dec.op_a >> shamt;
            cdb_pkg::ALU_SRA:  alu_res = $signed(i_dec.op_a) >>> shamt;
            cdb_pkg::ALU_OR:   alu_res = i_dec.op_a | i_dec.op_b;
            cdb_pkg::ALU_AND:  alu_res = i_dec.op_a & i_dec.op_b;
            // Branch compares leave the data at zero
            cdb_pkg::ALU_EQ:   taken = eq;
            cdb_pkg::ALU_NE:   taken = ~eq;
            cdb_pkg::ALU_LT:   taken = lt_s;
            cdb_pkg::ALU_GE:   taken = ~lt_s;
            cdb_pkg::ALU_LTU:  taken = lt_u;
            default:           taken = ~lt_u;
        endcase
    end

    assign link_addr = i_dec.iaddr + cdb_pkg::ADDR_WIDTH'(4);
    assign br_target = i_dec.iaddr + i_dec.imm_b;
    assign jalr_sum  = i_dec.op_a + i_dec.imm_b;

    // Not-taken prediction, so any taken branch or jump redirects fetch
    assign redirect = i_dec.jmp | (i_dec.br & taken);

    always_comb begin
        o_result          = '0;
        o_result.valid    = i_dec.valid;
        o_result.tag      = i_dec.tag;
        o_result.redirect = redirect;
        o_result.data     = i_dec.jmp ? link_addr : alu_res;
        if (i_dec.jalr) begin
            o_result.addr = {jalr_sum[cdb_pkg::ADDR_WIDTH-1:1], 1'b0};
        end else if (redirect) begin
            o_result.addr = br_target;
        end else begin
            o_result.addr = link_addr;
        end
    end

endmodule

// ==== ieu/ieu_decode.sv ====
// ID stage of an integer unit. Purely combinational: turns the issued
// instruction into an ALU function, selected operands and jump/branch flags
module ieu_decode (
    input  cdb_pkg::rs_issue_t i_issue,
    output cdb_pkg::decoded_t  o_dec
);

    logic [6:0]                      opcode;
    logic [2:0]                      funct3;
    logic                            alt;
    logic [cdb_pkg::DATA_WIDTH-1:0]  imm_i;
    logic [cdb_pkg::DATA_WIDTH-1:0]  imm_u;
    logic [cdb_pkg::DATA_WIDTH-1:0]  imm_j;
    logic [cdb_pkg::DATA_WIDTH-1:0]  imm_br;

    assign opcode = i_issue.insn[6:0];
    assign funct3 = i_issue.insn[14:12];
    // Bit 30 selects SUB and SRA
    assign alt    = i_issue.insn[30];

    assign imm_i  = {{20{i_issue.insn[31]}}, i_issue.insn[31:20]};
    assign imm_u  = {i_issue.insn[31:12], 12'b0};
    assign imm_j  = {{12{i_issue.insn[31]}}, i_issue.insn[19:12], i_issue.insn[20],
                     i_issue.insn[30:21], 1'b0};
    assign imm_br = {{20{i_issue.insn[31]}}, i_issue.insn[7], i_issue.insn[30:25],
                     i_issue.insn[11:8], 1'b0};

    function automatic cdb_pkg::alu_func_t arith_func(input logic [2:0] f3,
                                                      input logic       sub_sra);
        case (f3)
            3'b000:  return sub_sra ? cdb_pkg::ALU_SUB : cdb_pkg::ALU_ADD;
            3'b001:  return cdb_pkg::ALU_SLL;
            3'b010:  return cdb_pkg::ALU_SLT;
            3'b011:  return cdb_pkg::ALU_SLTU;
            3'b100:  return cdb_pkg::ALU_XOR;
            3'b101:  return sub_sra ? cdb_pkg::ALU_SRA : cdb_pkg::ALU_SRL;
            3'b110:  return cdb_pkg::ALU_OR;
            default: return cdb_pkg::ALU_AND;
        endcase
    endfunction

    function automatic cdb_pkg::alu_func_t branch_func(input logic [2:0] f3);
        case (f3)
            3'b001:  return cdb_pkg::ALU_NE;
            3'b100:  return cdb_pkg::ALU_LT;
            3'b101:  return cdb_pkg::ALU_GE;
            3'b110:  return cdb_pkg::ALU_LTU;
            3'b111:  return cdb_pkg::ALU_GEU;
            default: return cdb_pkg::ALU_EQ;
        endcase
    endfunction

    always_comb begin
        o_dec          = '0;
        o_dec.valid    = i_issue.valid;
        o_dec.iaddr    = i_issue.iaddr;
        o_dec.tag      = i_issue.tag;
        o_dec.alu_func = cdb_pkg::ALU_ADD;
        o_dec.op_a     = i_issue.src_a;
        o_dec.op_b     = i_issue.src_b;
        case (opcode)
            cdb_pkg::OPC_OP: begin
                o_dec.alu_func = arith_func(funct3, alt);
            end
            cdb_pkg::OPC_OP_IMM: begin
                // No SUBI, so bit 30 only matters for right shifts
                o_dec.alu_func = arith_func(funct3, alt & (funct3 == 3'b101));
                o_dec.op_b     = imm_i;
            end
            cdb_pkg::OPC_LUI: begin
                o_dec.op_a = '0;
                o_dec.op_b = imm_u;
            end
            cdb_pkg::OPC_AUIPC: begin
                o_dec.op_a = i_issue.iaddr;
                o_dec.op_b = imm_u;
            end
            cdb_pkg::OPC_JAL: begin
                o_dec.imm_b = imm_j;
                o_dec.jmp   = 1'b1;
            end
            cdb_pkg::OPC_JALR: begin
                o_dec.imm_b = imm_i;
                o_dec.jmp   = 1'b1;
                o_dec.jalr  = 1'b1;
            end
            cdb_pkg::OPC_BRANCH: begin
                o_dec.alu_func = branch_func(funct3);
                o_dec.imm_b    = imm_br;
                o_dec.br       = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hdl/result_fifo.sv ====
// Synchronous circular FIFO of CDB results with flush and occupancy count.
// Head entry is visible on o_data; a read and a write may share a cycle
module result_fifo #(
    parameter int DEPTH = cdb_pkg::RESULT_FIFO_DEPTH
) (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       i_flush,
    input  logic                       i_wr,
    input  cdb_pkg::cdb_t              i_data,
    input  logic                       i_rd,
    output cdb_pkg::cdb_t              o_data,
    output logic                       o_empty,
    output logic                       o_full,
    output logic [$clog2(DEPTH+1)-1:0] o_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    if ((DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("result_fifo DEPTH must be a power of two");
    end

    cdb_pkg::cdb_t    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             wr_en;
    logic             rd_en;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == ($clog2(DEPTH+1))'(DEPTH));
    assign rd_en   = i_rd & ~o_empty;
    // When full, a write only lands if the head leaves this cycle
    assign wr_en   = i_wr & (~o_full | rd_en);
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else if (i_flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                o_count <= o_count + 1'b1;
            end else if (rd_en && !wr_en) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (!n_rst || i_flush)
        i_rd |-> !o_empty
    );

    a_no_write_full: assert property (
        @(posedge clk) disable iff (!n_rst || i_flush)
        (i_wr && o_full) |-> i_rd
    );

endmodule

// ==== common/cdb_pkg.sv ====
// Shared widths, RV32I opcode values and the structs that pass between
// the execution units, their result queues and the CDB arbiter
package cdb_pkg;

    localparam int DATA_WIDTH        = 32;
    localparam int ADDR_WIDTH        = 32;
    localparam int INSN_WIDTH        = 32;
    localparam int TAG_WIDTH         = 6;
    localparam int NUM_FU            = 2;
    localparam int RESULT_FIFO_DEPTH = 8;

    // Derived widths for the arbiter pointer and the FIFO occupancy
    localparam int FU_IDX_WIDTH   = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;
    localparam int FIFO_CNT_WIDTH = $clog2(RESULT_FIFO_DEPTH + 1);

    // Major opcodes handled by the integer units
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_func_t;

    typedef struct packed {
        logic                  valid;
        logic [INSN_WIDTH-1:0] insn;
        logic [ADDR_WIDTH-1:0] iaddr;
        logic [DATA_WIDTH-1:0] src_a;
        logic [DATA_WIDTH-1:0] src_b;
        logic [TAG_WIDTH-1:0]  tag;
    } rs_issue_t;

    typedef struct packed {
        logic                  valid;
        alu_func_t             alu_func;
        logic [DATA_WIDTH-1:0] op_a;
        logic [DATA_WIDTH-1:0] op_b;
        logic [DATA_WIDTH-1:0] imm_b;
        logic [ADDR_WIDTH-1:0] iaddr;
        logic [TAG_WIDTH-1:0]  tag;
        logic                  jmp;
        logic                  jalr;
        logic                  br;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
        logic [ADDR_WIDTH-1:0] addr;
        logic [TAG_WIDTH-1:0]  tag;
        logic                  redirect;
    } cdb_t;

endpackage
